//--- bench/tbStim.svh
// LDPC input front end testbench stimulus
// Frame table, xorshift generator and reference model helpers

`ifndef TBSTIM_SVH
`define TBSTIM_SVH

//----------------------------------------
// Frame table
//----------------------------------------

localparam logic [1:0] kRandom = 2'd0;   // Random LLRs
localparam logic [1:0] kAllMin = 2'd1;   // Every LLR at -8
localparam logic [1:0] kRamp   = 2'd2;   // Lane ramp wrapping through all values

localparam logic [7:0] holdDly = 8'hff;  // Credits withheld until stall check
localparam int numFrames     = 6;
localparam int beatsPerFrame = frameWords * dwcFactor;
localparam int maxGap        = 8;        // Idle cycles allowed before one beat
localparam int worstDly      = 12;       // Longest timed credit return

typedef struct packed {
  logic [1:0] kind;
  logic [7:0] gapPct;     // Idle cycle chance in percent
  logic [7:0] creditDly;  // Cycles from oval to credit return
} frameCfg_t;

localparam frameCfg_t frameTable [numFrames] = '{
  '{kRandom, 8'd0,  holdDly},  // First two frames fill both banks
  '{kRamp,   8'd20, holdDly},
  '{kAllMin, 8'd0,  8'd0},
  '{kRandom, 8'd50, 8'd3},
  '{kRandom, 8'd10, 8'd12},
  '{kRamp,   8'd30, 8'd1}
};

//----------------------------------------
// Generator and reference helpers
//----------------------------------------

logic [31:0] rngState = 32'hbc5e7d71;

function automatic logic [31:0] xorshift32();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

// Raw LLR of one lane for a pattern kind
function automatic llr_t patternLlr(logic [1:0] kind, int beat, int lane);
  llr_t v;
  case (kind)
    kAllMin : v = llrMinVal;
    kRamp   : v = llr_t'(beat * llrNum + lane);
    default : v = llr_t'(xorshift32());
  endcase
  return v;
endfunction

// Negate, then clip to the positive limit
function automatic llr_t invertedLlr(llr_t v);
  int n;
  n = -int'(v);
  if (n > int'(llrMaxVal)) n = int'(llrMaxVal);  // Only -8 lands here
  return llr_t'(n);
endfunction

`endif

//--- bench/tbLdpcIn.sv
// LDPC input front end testbench
// Sends a table of frames through the DUT, models the expected
// words, returns credits with delay and checks flow control

`timescale 1ns/100ps

module tbLdpcIn;

  import ldpcInPkg::*;
  `include "tbStim.svh"

  localparam int resetCycles   = 10;
  localparam int timeoutCycles =
    2 * numFrames * beatsPerFrame * (maxGap + 1 + worstDly) + resetCycles;

  logic       iclk = 1'b0;
  logic       ireset;
  logic       ival;
  llrBeat_t   ibeat;
  logic       icredit = 1'b0;
  logic       ordy;
  logic       obusy;
  logic       oval;
  outWord_t   oword;

  outWord_t   expQ [$];          // Expected words in output order
  int         dueQ [$];          // Cycle at which each credit returns
  int         cycleCnt    = 0;
  int         creditDly   = 0;
  logic       holdCredits = 1'b0;
  int         outCount    = 0;   // Words seen on oval
  int         outstanding = 0;   // Words out minus credits returned
  int         heldFrames  = 0;

  ldpcInTop u_dut (
    .iclk(iclk), .ireset(ireset), .ival(ival), .ibeat(ibeat), .ordy(ordy),
    .obusy(obusy), .icredit(icredit), .oval(oval), .oword(oword)
  );

  always #2 iclk = ~iclk;  // 4 ns period

  //----------------------------------------
  // Checks
  //----------------------------------------

  task automatic checkVal(input logic [127:0] got, input logic [127:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  // Stalled reader with both banks taken
  task automatic checkStall();
    repeat (4) @(negedge iclk);
    checkVal(128'(ordy), 128'(1'b0), "ordy with both banks full");
    checkVal(128'(obusy), 128'(1'b1), "obusy with frames held");
    checkVal(128'(outCount), 128'(creditMax), "words sent without credit return");
  endtask

  //----------------------------------------
  // Frame driver
  //----------------------------------------

  task automatic sendFrame(input int f);
    frameCfg_t cfg;
    llrBeat_t  beat;
    llrWord_t  expWord;
    outWord_t  expOut;
    llr_t      raw;
    int        gaps;
    int        w;
    int        k;
    cfg     = frameTable[f];
    expWord = '0;
    @(negedge iclk);
    while (!ordy) @(negedge iclk);  // Stable until our own eop
    @(posedge iclk);
    for (int b = 0; b < beatsPerFrame; b++) begin
      gaps = 0;
      while (gaps < maxGap && int'(xorshift32() % 32'd100) < int'(cfg.gapPct)) begin
        ival <= 1'b0;
        gaps++;
        @(posedge iclk);
      end
      w        = b / dwcFactor;
      k        = b % dwcFactor;
      beat.sop = (b == 0);
      beat.eop = (b == beatsPerFrame - 1);
      for (int j = 0; j < llrNum; j++) begin
        raw                      = patternLlr(cfg.kind, b, j);
        beat.llr[j]              = raw;
        expWord[k * llrNum + j]  = invertedLlr(raw);  // Beat k in lanes 4k..4k+3
      end
      if (k == dwcFactor - 1) begin
        expOut.sop  = (w == 0);
        expOut.eop  = (w == frameWords - 1);
        expOut.word = expWord;
        expQ.push_back(expOut);
      end
      ival  <= 1'b1;
      ibeat <= beat;
      @(posedge iclk);
    end
    ival <= 1'b0;  // Idle while frame done is pending
  endtask

  //----------------------------------------
  // Credit return and output monitor
  //----------------------------------------

  always @(posedge iclk) begin
    cycleCnt = cycleCnt + 1;
    if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycleCnt) begin
      void'(dueQ.pop_front());
      icredit <= 1'b1;
    end else begin
      icredit <= 1'b0;
    end
  end

  // Outputs sampled mid cycle
  always @(negedge iclk) begin
    if (!ireset) begin
      if (oval) begin
        if (expQ.size() == 0) begin
          checkVal(128'(1'b0), 128'(1'b1), "output word with no frame pending");
        end else begin
          checkVal(128'(oword), 128'(expQ.pop_front()),
                   $sformatf("output word %0d", outCount));
        end
        outCount++;
        outstanding++;
        dueQ.push_back(cycleCnt + creditDly);
      end
      if (icredit) outstanding--;
      checkVal(128'(outstanding <= creditMax), 128'(1'b1), "words in flight beyond credits");
    end
  end

  //----------------------------------------
  // Watchdog
  //----------------------------------------

  initial begin
    repeat (timeoutCycles) @(posedge iclk);
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation timed out");
  end

  //----------------------------------------
  // Main sequence
  //----------------------------------------

  initial begin
    ireset  <= 1'b1;
    ival    <= 1'b0;
    ibeat   <= '0;
    repeat (resetCycles) @(posedge iclk);
    ireset <= 1'b0;

    @(negedge iclk);  // Idle state after reset
    checkVal(128'(oval), 128'(1'b0), "oval after reset");
    checkVal(128'(ordy), 128'(1'b1), "ordy after reset");
    checkVal(128'(obusy), 128'(1'b0), "obusy after reset");
    checkVal(128'(u_dut.wr.write), 128'(1'b0), "write strobe after reset");
    checkVal(128'(u_dut.frameDone), 128'(1'b0), "frame done after reset");
    checkVal(128'(u_dut.rdRelease), 128'(1'b0), "release after reset");
    @(posedge iclk);

    for (int f = 0; f < numFrames; f++) begin
      if (frameTable[f].creditDly == holdDly) begin
        holdCredits = 1'b1;
        creditDly   = 0;
      end else begin
        creditDly = int'(frameTable[f].creditDly);
      end
      sendFrame(f);
      if (holdCredits) begin
        heldFrames++;
        if (heldFrames == 2) begin
          checkStall();
          holdCredits = 1'b0;  // Credits flow again
          heldFrames  = 0;
        end
      end
    end

    while (expQ.size() != 0) @(negedge iclk);  // Drain
    repeat (8) @(negedge iclk);
    checkVal(128'(outCount), 128'(numFrames * frameWords), "total output words");
    checkVal(128'(obusy), 128'(1'b0), "obusy after drain");
    checkVal(128'(ordy), 128'(1'b1), "ordy after drain");

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- common/ldpcInPkg.sv
// LDPC input front end shared definitions
// Sizes of LLRs, words and frames, flow control limits,
// bus structs and the reader FSM state type

package ldpcInPkg;

  //----------------------------------------
  // Sizes
  //----------------------------------------

  localparam int llrW       = 4;                  // Bits per LLR
  localparam int llrNum     = 4;                  // LLRs per input beat
  localparam int wNum       = 16;                 // LLRs per buffer word
  localparam int dwcFactor  = wNum / llrNum;      // Beats per word
  localparam int dwcCntW    = $clog2(dwcFactor);  // Beat counter width
  localparam int frameWords = 8;                  // Words per frame and per bank
  localparam int waddrW     = $clog2(frameWords); // Word address inside a bank

  // Downstream flow control
  localparam int creditMax  = 4;                  // Credits held after reset
  localparam int creditW    = $clog2(creditMax + 1);

  //----------------------------------------
  // LLR type and limits
  //----------------------------------------

  typedef logic signed [llrW-1:0] llr_t;

  localparam llr_t llrMinVal = llr_t'(-(2 ** (llrW - 1)));  // -8
  localparam llr_t llrMaxVal = llr_t'((2 ** (llrW - 1)) - 1); // +7

  //----------------------------------------
  // Bus types
  //----------------------------------------

  // One input beat of 18 bits
  typedef struct packed {
    logic                   sop;
    logic                   eop;
    llr_t [llrNum-1:0]      llr;   // Lane 0 in low bits
  } llrBeat_t;

  // One buffer word with lane 0 in the lowest bits
  typedef llr_t [wNum-1:0] llrWord_t;

  // Source to buffer write port of 68 bits
  typedef struct packed {
    logic                   write; // Single cycle strobe
    logic [waddrW-1:0]      addr;  // Word address in the write bank
    llrWord_t               word;
  } bufWrite_t;

  // Output word toward the decoder core of 66 bits
  typedef struct packed {
    logic                   sop;   // First word of frame
    logic                   eop;   // Last word of frame
    llrWord_t               word;
  } outWord_t;

  // Reader FSM
  typedef enum logic [1:0] {
    stIdle,
    stRead,
    stRelease
  } readerState_t;

endpackage

//--- inBuffer/inBuffer.sv
// LDPC input ping-pong buffer
// Two banks of word RAM with per-bank full flags, separate write
// and read bank pointers, and occupancy status for the source

`timescale 1ns/100ps

module inBuffer (
  input  logic                          iclk,
  input  logic                          ireset,
  input  ldpcInPkg::bufWrite_t          wr,
  input  logic                          frameDone,
  input  logic                          rdEn,
  input  logic [ldpcInPkg::waddrW-1:0]  rdAddr,
  input  logic                          rdRelease,
  output logic                          rdFull,
  output ldpcInPkg::llrWord_t           rdWord,
  output logic                          bankFull,
  output logic                          anyFull
);

  import ldpcInPkg::*;

  //----------------------------------------
  // Signals
  //----------------------------------------

  localparam int ramDepth = 2 * frameWords;

  llrWord_t   ram [ramDepth];  // Bank bit is the address MSB
  logic       wrBank;          // Bank being filled
  logic       rdBank;          // Bank being drained
  logic [1:0] full;            // One flag per bank

  logic [waddrW:0] wrRamAddr;
  logic [waddrW:0] rdRamAddr;

  assign wrRamAddr = {wrBank, wr.addr};
  assign rdRamAddr = {rdBank, rdAddr};

  //----------------------------------------
  // RAM
  //----------------------------------------

  always_ff @(posedge iclk) begin
    if (wr.write) begin
      ram[wrRamAddr] <= wr.word;
    end
  end

  // Registered read with the word one cycle after rdEn
  always_ff @(posedge iclk) begin
    if (rdEn) begin
      rdWord <= ram[rdRamAddr];
    end
  end

  //----------------------------------------
  // Bank pointers and full flags
  //----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wrBank <= 1'b0;
      rdBank <= 1'b0;
    end else begin
      if (frameDone) begin
        wrBank <= ~wrBank;  // Next frame goes to the other bank
      end
      if (rdRelease) begin
        rdBank <= ~rdBank;
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      full <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (frameDone && (wrBank == b[0])) begin
          full[b] <= 1'b1;  // Frame complete in this bank
        end else if (rdRelease && (rdBank == b[0])) begin
          full[b] <= 1'b0;  // Reader is done with it
        end
      end
    end
  end

  // Status
  assign rdFull   = full[rdBank];
  assign bankFull = &full;
  assign anyFull  = |full;

  //----------------------------------------
  // Checks
  //----------------------------------------

  // Source must stall once both banks are taken
  aNoOverflow : assert property (
    @(posedge iclk) disable iff (ireset) frameDone |-> !bankFull
  );

  // Reader only frees a bank it was allowed to read
  aNoEmptyRelease : assert property (
    @(posedge iclk) disable iff (ireset) rdRelease |-> rdFull
  );

endmodule

//--- ldpcSource/ldpcSource.sv
// LDPC input source
// Saturates and sign-inverts incoming LLRs, packs four beats
// into one buffer word and generates the buffer write address
// and the frame done pulse

`timescale 1ns/100ps

module ldpcSource (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  ival,
  input  ldpcInPkg::llrBeat_t   ibeat,
  input  logic                  bankFull,  // Both banks hold a frame
  input  logic                  anyFull,   // Some bank holds a frame
  output logic                  ordy,
  output logic                  obusy,
  output ldpcInPkg::bufWrite_t  wr,
  output logic                  frameDone
);

  import ldpcInPkg::*;

  //----------------------------------------
  // Signals
  //----------------------------------------

  llr_t [llrNum-1:0]  satBeat;   // Saturated, inverted beat
  logic [dwcCntW-1:0] beatCnt;   // Beats in the current word
  logic [dwcCntW-1:0] beatIdx;   // Position of the incoming beat
  logic               lastBeat;  // Incoming beat completes a word
  logic               wrStb;
  logic [waddrW-1:0]  wAddr;
  llrWord_t           wordReg;

  //----------------------------------------
  // Saturation and inversion
  //----------------------------------------

  // Most negative value has no positive twin so it clips to max
  function automatic llr_t satInv(llr_t x);
    llr_t res;
    if (x == llrMinVal) begin
      res = llrMaxVal;
    end else begin
      res = llr_t'(-x);
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < llrNum; i++) begin
      satBeat[i] = satInv(ibeat.llr[i]);
    end
  end

  //----------------------------------------
  // Beat counter and write strobe
  //----------------------------------------

  assign beatIdx  = ibeat.sop ? '0 : beatCnt;  // Sop restarts packing
  assign lastBeat = (beatIdx == dwcCntW'(dwcFactor - 1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beatCnt   <= '0;
      wrStb     <= 1'b0;
      wAddr     <= '0;
      frameDone <= 1'b0;
    end else begin
      wrStb     <= ival & lastBeat;      // One cycle after fourth beat
      frameDone <= ival & ibeat.eop;     // One cycle after eop
      if (ival) begin
        beatCnt <= lastBeat ? '0 : beatIdx + 1'b1;
      end
      // Address restarts on sop, steps after every word write
      if (ival && ibeat.sop) begin
        wAddr <= '0;
      end else if (wrStb) begin
        wAddr <= wAddr + 1'b1;
      end
    end
  end

  // Word shift register filled LSB first
  // Newest beat lands in the top lanes, beat 0 ends in lanes 0..3
  always_ff @(posedge iclk) begin
    if (ival) begin
      wordReg <= {satBeat, wordReg[wNum-1:llrNum]};
    end
  end

  assign wr.write = wrStb;
  assign wr.addr  = wAddr;
  assign wr.word  = wordReg;

  //----------------------------------------
  // Status toward the outside
  //----------------------------------------

  assign ordy  = !bankFull && !frameDone;  // Pending frame done blocks input
  assign obusy =  anyFull  ||  frameDone;

  //----------------------------------------
  // Checks
  //----------------------------------------

  // Upstream honours ordy
  aNoBeatWhenBusy : assert property (
    @(posedge iclk) disable iff (ireset) ival |-> ordy
  );

  // Eop must close a whole word
  aEopOnWordEnd : assert property (
    @(posedge iclk) disable iff (ireset) (ival && ibeat.eop) |-> lastBeat
  );

endmodule

//--- logic/creditReader.sv
// Credit based buffer reader
// Drains a full bank word by word while downstream credits are
// available, tags frame boundaries and then releases the bank

`timescale 1ns/100ps

module creditReader (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          rdFull,
  input  logic                          icredit,   // One pulse per consumed word
  output logic                          rdEn,
  output logic [ldpcInPkg::waddrW-1:0]  rdAddr,
  output logic                          rdRelease,
  input  ldpcInPkg::llrWord_t           rdWord,
  output logic                          oval,
  output ldpcInPkg::outWord_t           oword
);

  import ldpcInPkg::*;

  readerState_t       state;
  logic [waddrW-1:0]  wordCnt;
  logic [creditW-1:0] credit;
  logic               lastWord;
  logic               sopTag;
  logic               eopTag;

  //----------------------------------------
  // Read control
  //----------------------------------------

  assign rdEn      = (state == stRead) && (credit != '0);  // Pause without credit
  assign rdAddr    = wordCnt;
  assign rdRelease = (state == stRelease);
  assign lastWord  = (wordCnt == waddrW'(frameWords - 1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= stIdle;
      wordCnt <= '0;
    end else begin
      case (state)
        stIdle    : begin
          wordCnt <= '0;
          if (rdFull) state <= stRead;
        end
        stRead    : begin
          if (rdEn) begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord) state <= stRelease;
          end
        end
        stRelease : state <= stIdle;  // Bank freed this cycle
        default   : state <= stIdle;
      endcase
    end
  end

  // Credits spent on read and refilled on return
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      credit <= creditW'(creditMax);
    end else begin
      credit <= credit - creditW'(rdEn) + creditW'(icredit);
    end
  end

  //----------------------------------------
  // Output aligned with RAM read latency
  //----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval   <= 1'b0;
      sopTag <= 1'b0;
      eopTag <= 1'b0;
    end else begin
      oval   <= rdEn;
      sopTag <= rdEn && (wordCnt == '0);
      eopTag <= rdEn && lastWord;
    end
  end

  assign oword.sop  = sopTag;
  assign oword.eop  = eopTag;
  assign oword.word = rdWord;

  // Downstream never returns more than it was given
  aCreditLimit : assert property (
    @(posedge iclk) disable iff (ireset) credit <= creditW'(creditMax)
  );

endmodule

//--- logic/ldpcInTop.sv
// LDPC decoder input front end top
// Source feeds the ping-pong buffer, the credit reader drains it

`timescale 1ns/100ps

module ldpcInTop (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 ival,
  input  ldpcInPkg::llrBeat_t  ibeat,
  output logic                 ordy,
  output logic                 obusy,
  input  logic                 icredit,
  output logic                 oval,
  output ldpcInPkg::outWord_t  oword
);

  import ldpcInPkg::*;

  bufWrite_t         wr;
  logic              frameDone;
  logic              bankFull;
  logic              anyFull;
  logic              rdFull;
  logic              rdEn;
  logic [waddrW-1:0] rdAddr;
  logic              rdRelease;
  llrWord_t          rdWord;

  //----------------------------------------
  // Write side
  //----------------------------------------

  ldpcSource u_source (
    .iclk(iclk), .ireset(ireset), .ival(ival), .ibeat(ibeat),
    .bankFull(bankFull), .anyFull(anyFull), .ordy(ordy), .obusy(obusy),
    .wr(wr), .frameDone(frameDone)
  );

  inBuffer u_buffer (
    .iclk(iclk), .ireset(ireset), .wr(wr), .frameDone(frameDone),
    .rdEn(rdEn), .rdAddr(rdAddr), .rdRelease(rdRelease), .rdFull(rdFull),
    .rdWord(rdWord), .bankFull(bankFull), .anyFull(anyFull)
  );

  // Read side toward the decoder core
  creditReader u_reader (
    .iclk(iclk), .ireset(ireset), .rdFull(rdFull), .icredit(icredit),
    .rdEn(rdEn), .rdAddr(rdAddr), .rdRelease(rdRelease), .rdWord(rdWord),
    .oval(oval), .oword(oword)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the LDPC input front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tbLdpcIn \
  -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
  fi
  echo "Test passed"
  exit 0
fi

echo "Test failed, see sim.log"
exit 1

//--- vlog.f
+incdir+bench
common/ldpcInPkg.sv
ldpcSource/ldpcSource.sv
inBuffer/inBuffer.sv
logic/creditReader.sv
logic/ldpcInTop.sv
bench/tbLdpcIn.sv
